/* source/periph_pkg.sv */
// Peripheral block package
// APB widths, register offsets, bit-bang register fields,
// peripheral select enum and parameter defaults

`default_nettype none

package periph_pkg;

    // APB port widths
    localparam int apb_addr_w = 12;
    localparam int apb_data_w = 32;

    // Register offsets
    localparam logic [apb_addr_w-1:0] addr_status = 12'h000;
    localparam logic [apb_addr_w-1:0] addr_dsp_a  = 12'h010;
    localparam logic [apb_addr_w-1:0] addr_dsp_b  = 12'h014;
    localparam logic [apb_addr_w-1:0] addr_pad    = 12'h020;
    localparam logic [apb_addr_w-1:0] addr_flash  = 12'h030;

    // Decoded target of a transfer
    typedef enum logic [2:0] {
        sel_none   = 3'd0,
        sel_status = 3'd1,
        sel_dsp    = 3'd2,
        sel_pad    = 3'd3,
        sel_flash  = 3'd4
    } periph_sel_e;

    // Bit-bang register layout
    localparam int flash_field_w    = 4;
    localparam int flash_out_lsb    = 0;
    localparam int flash_oe_lsb     = 4;
    localparam int flash_clk_bit    = 8;
    localparam int flash_csn_bit    = 9;
    localparam int flash_active_bit = 15;

    // Bit 0 drives led_r, bit 1 drives led_b
    localparam logic [1:0] status_reset_value = 2'b01;

    // Defaults handed down by the top level
    localparam int dsp_width_default = 16;
    localparam int pad_bits_default  = 16;

endpackage

`default_nettype wire

/* source/periph_apb_bus.sv */
// APB slave for the peripheral block
// Address decode, write strobes, LED status register, read-data mux

`timescale 1ns/1ns
`default_nettype none

module periph_apb_bus (
    input  wire                                vdp_clk,
    input  wire                                vdp_reset,

    input  wire                                psel,
    input  wire                                penable,
    input  wire                                pwrite,
    input  wire  [periph_pkg::apb_addr_w-1:0]  paddr,
    input  wire  [periph_pkg::apb_data_w-1:0]  pwdata,
    output logic [periph_pkg::apb_data_w-1:0]  prdata,
    output logic                               pready,
    output logic                               pslverr,

    output logic                               dsp_write_a,
    output logic                               dsp_write_b,
    output logic                               pad_write,
    output logic                               flash_write,

    input  wire  [periph_pkg::apb_data_w-1:0]  dsp_result,
    input  wire  [1:0]                         pad_data,
    input  wire  [3:0]                         flash_sample,

    output logic                               led_r,
    output logic                               led_b
);

    periph_pkg::periph_sel_e sel;

    logic       access;
    logic       write_access;
    logic       status_write;
    logic [1:0] status;

    // Both operand offsets map onto the multiplier
    always_comb begin
        case (paddr)
            periph_pkg::addr_status: sel = periph_pkg::sel_status;
            periph_pkg::addr_dsp_a:  sel = periph_pkg::sel_dsp;
            periph_pkg::addr_dsp_b:  sel = periph_pkg::sel_dsp;
            periph_pkg::addr_pad:    sel = periph_pkg::sel_pad;
            periph_pkg::addr_flash:  sel = periph_pkg::sel_flash;
            default:                 sel = periph_pkg::sel_none;
        endcase
    end

    // No wait states
    assign access       = psel && penable;
    assign write_access = access && pwrite;
    assign pready       = access;
    assign pslverr      = access && (sel == periph_pkg::sel_none);

    // Strobes last exactly the access cycle
    assign status_write = write_access && (sel == periph_pkg::sel_status);
    assign dsp_write_a  = write_access && (paddr == periph_pkg::addr_dsp_a);
    assign dsp_write_b  = write_access && (paddr == periph_pkg::addr_dsp_b);
    assign pad_write    = write_access && (sel == periph_pkg::sel_pad);
    assign flash_write  = write_access && (sel == periph_pkg::sel_flash);

    // LED status
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            status <= periph_pkg::status_reset_value;
        end else if (status_write) begin
            status <= pwdata[1:0];
        end
    end

    assign led_r = status[0];
    assign led_b = status[1];

    // Read data, zero-extended, only driven in the access cycle
    always_comb begin
        prdata = '0;
        if (access) begin
            case (sel)
                periph_pkg::sel_status: prdata[1:0] = status;
                periph_pkg::sel_dsp:    prdata      = dsp_result;
                periph_pkg::sel_pad:    prdata[1:0] = pad_data;
                periph_pkg::sel_flash:  prdata[3:0] = flash_sample;
                default:                prdata      = '0;
            endcase
        end
    end

    // Master side of the handshake
    penable_needs_psel: assert property (
        @(posedge vdp_clk) disable iff (vdp_reset) penable |-> psel
    ) else $error("penable high without psel");

    // Strobes go to different modules and must never overlap
    write_strobes_onehot: assert property (
        @(posedge vdp_clk) disable iff (vdp_reset)
        $onehot0({status_write, dsp_write_a, dsp_write_b, pad_write, flash_write})
    ) else $error("more than one write strobe active");

endmodule

`default_nettype wire

/* source/dsp_mult.sv */
// Signed multiplier peripheral
// Two write-only operand registers and a registered product

`timescale 1ns/1ns
`default_nettype none

module dsp_mult #(
    parameter int dsp_width = 16
) (
    input  wire                                vdp_clk,

    input  wire                                dsp_write_a,
    input  wire                                dsp_write_b,
    input  wire  [periph_pkg::apb_data_w-1:0]  pwdata,

    output logic [2*dsp_width-1:0]             dsp_result
);

    logic signed [dsp_width-1:0] operand_a;
    logic signed [dsp_width-1:0] operand_b;

    // Kept as two flat ifs so the operands can pack into a hard multiplier
    always_ff @(posedge vdp_clk) begin
        if (dsp_write_a) begin
            operand_a <= pwdata[dsp_width-1:0];
        end

        if (dsp_write_b) begin
            operand_b <= pwdata[dsp_width-1:0];
        end
    end

    // Product lags the operands by one clock
    always_ff @(posedge vdp_clk) begin
        dsp_result <= operand_a * operand_b;
    end

endmodule

`default_nettype wire

/* source/pad_reader.sv */
// Gamepad mock
// Latches the three buttons into a shift register that software
// clocks through the pad control bits

`timescale 1ns/1ns
`default_nettype none

module pad_reader #(
    parameter int pad_bits = 16
) (
    input  wire                                vdp_clk,
    input  wire                                vdp_reset,

    input  wire                                pad_write,
    input  wire  [periph_pkg::apb_data_w-1:0]  pwdata,

    input  wire                                btn_1,
    input  wire                                btn_2,
    input  wire                                btn_3,

    output logic [1:0]                         pad_data
);

    logic                pad_latch;
    logic                pad_clk;
    logic                pad_clk_prev;
    logic                pad_clk_rise;
    logic [pad_bits-1:0] load_pattern;
    logic [pad_bits-1:0] shift_reg;

    // Control bits, bit 0 latch and bit 1 clock
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            pad_latch    <= 1'b0;
            pad_clk      <= 1'b0;
            pad_clk_prev <= 1'b0;
        end else begin
            if (pad_write) begin
                pad_latch <= pwdata[0];
                pad_clk   <= pwdata[1];
            end
            pad_clk_prev <= pad_clk;
        end
    end

    assign pad_clk_rise = pad_clk && !pad_clk_prev;

    // Button positions match a real pad's left, right and B
    always_comb begin
        load_pattern    = '0;
        load_pattern[7] = btn_1;
        load_pattern[6] = btn_3;
        load_pattern[0] = btn_2;
    end

    // Shift has priority over the latch load
    always_ff @(posedge vdp_clk) begin
        if (pad_clk_rise) begin
            shift_reg <= {1'b0, shift_reg[pad_bits-1:1]};
        end else if (pad_latch) begin
            shift_reg <= load_pattern;
        end
    end

    assign pad_data = {1'b0, shift_reg[0]};

    // Second data line is not wired on the mock
    pad_data_hi_zero: assert property (
        @(posedge vdp_clk) disable iff (vdp_reset) pad_data[1] == 1'b0
    ) else $error("pad_data bit 1 set");

endmodule

`default_nettype wire

/* source/flash_bitbang.sv */
// Flash bit-bang register
// Software-driven flash pins with idle levels when inactive,
// plus a registered sample of the flash data lines

`timescale 1ns/1ns
`default_nettype none

module flash_bitbang (
    input  wire                                vdp_clk,
    input  wire                                vdp_reset,

    input  wire                                flash_write,
    input  wire  [periph_pkg::apb_data_w-1:0]  pwdata,

    output logic                               flash_clk,
    output logic                               flash_csn,
    output logic [3:0]                         flash_io_out,
    output logic [3:0]                         flash_io_oe,
    input  wire  [3:0]                         flash_io_in,

    output logic [3:0]                         flash_sample
);

    logic       active;
    logic       clk_field;
    logic       csn_field;
    logic [3:0] out_field;
    logic [3:0] oe_field;

    // Pin fields
    always_ff @(posedge vdp_clk) begin
        if (flash_write) begin
            out_field <= pwdata[periph_pkg::flash_out_lsb +: periph_pkg::flash_field_w];
            oe_field  <= pwdata[periph_pkg::flash_oe_lsb +: periph_pkg::flash_field_w];
            clk_field <= pwdata[periph_pkg::flash_clk_bit];
            csn_field <= pwdata[periph_pkg::flash_csn_bit];
        end
    end

    // Ownership of the pins
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            active <= 1'b0;
        end else if (flash_write) begin
            active <= pwdata[periph_pkg::flash_active_bit];
        end
    end

    // Idle: clock low, chip deselected, data lines released
    assign flash_clk    = active ? clk_field : 1'b0;
    assign flash_csn    = active ? csn_field : 1'b1;
    assign flash_io_out = active ? out_field : 4'b0000;
    assign flash_io_oe  = active ? oe_field  : 4'b0000;

    always_ff @(posedge vdp_clk) begin
        flash_sample <= flash_io_in;
    end

    // The bus must never be driven once software releases the pins
    oe_idle_when_inactive: assert property (
        @(posedge vdp_clk) disable iff (vdp_reset) !active |-> (flash_io_oe == 4'b0000)
    ) else $error("flash_io_oe driven while inactive");

endmodule

`default_nettype wire

/* source/periph_top.sv */
// Peripheral block top level
// APB slave plus multiplier, gamepad mock and flash bit-bang

`timescale 1ns/1ns
`default_nettype none

module periph_top #(
    parameter int dsp_width = periph_pkg::dsp_width_default,
    parameter int pad_bits  = periph_pkg::pad_bits_default
) (
    input  wire                                vdp_clk,
    input  wire                                vdp_reset,

    input  wire                                psel,
    input  wire                                penable,
    input  wire                                pwrite,
    input  wire  [periph_pkg::apb_addr_w-1:0]  paddr,
    input  wire  [periph_pkg::apb_data_w-1:0]  pwdata,
    output logic [periph_pkg::apb_data_w-1:0]  prdata,
    output logic                               pready,
    output logic                               pslverr,

    output logic                               led_r,
    output logic                               led_b,

    input  wire                                btn_1,
    input  wire                                btn_2,
    input  wire                                btn_3,

    output logic                               flash_clk,
    output logic                               flash_csn,
    output logic [3:0]                         flash_io_out,
    output logic [3:0]                         flash_io_oe,
    input  wire  [3:0]                         flash_io_in
);

    logic                   dsp_write_a;
    logic                   dsp_write_b;
    logic                   pad_write;
    logic                   flash_write;

    logic [2*dsp_width-1:0] dsp_result;
    logic [1:0]             pad_data;
    logic [3:0]             flash_sample;

    periph_apb_bus i_periph_apb_bus (
        .vdp_clk      (vdp_clk),
        .vdp_reset    (vdp_reset),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .dsp_write_a  (dsp_write_a),
        .dsp_write_b  (dsp_write_b),
        .pad_write    (pad_write),
        .flash_write  (flash_write),
        .dsp_result   (dsp_result),
        .pad_data     (pad_data),
        .flash_sample (flash_sample),
        .led_r        (led_r),
        .led_b        (led_b)
    );

    dsp_mult #(
        .dsp_width (dsp_width)
    ) i_dsp_mult (
        .vdp_clk     (vdp_clk),
        .dsp_write_a (dsp_write_a),
        .dsp_write_b (dsp_write_b),
        .pwdata      (pwdata),
        .dsp_result  (dsp_result)
    );

    pad_reader #(
        .pad_bits (pad_bits)
    ) i_pad_reader (
        .vdp_clk   (vdp_clk),
        .vdp_reset (vdp_reset),
        .pad_write (pad_write),
        .pwdata    (pwdata),
        .btn_1     (btn_1),
        .btn_2     (btn_2),
        .btn_3     (btn_3),
        .pad_data  (pad_data)
    );

    flash_bitbang i_flash_bitbang (
        .vdp_clk      (vdp_clk),
        .vdp_reset    (vdp_reset),
        .flash_write  (flash_write),
        .pwdata       (pwdata),
        .flash_clk    (flash_clk),
        .flash_csn    (flash_csn),
        .flash_io_out (flash_io_out),
        .flash_io_oe  (flash_io_oe),
        .flash_io_in  (flash_io_in),
        .flash_sample (flash_sample)
    );

endmodule

`default_nettype wire

/* test/tb_clock.sv */
// Testbench clock and reset
// Free-running vdp_clk and a reset held for a set number of cycles

`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
    parameter int period_ns    = 10,
    parameter int reset_cycles = 4
) (
    output logic vdp_clk,
    output logic vdp_reset
);

    initial begin
        vdp_clk = 1'b0;
        forever #(period_ns / 2) vdp_clk = ~vdp_clk;
    end

    // Released on a falling edge, away from the sampling edge
    initial begin
        vdp_reset = 1'b1;
        repeat (reset_cycles) @(posedge vdp_clk);
        @(negedge vdp_clk);
        vdp_reset = 1'b0;
    end

endmodule

`default_nettype wire

/* test/periph_checker.sv */
// Testbench checker
// Reference model of the peripheral registers and a per-clock
// comparison of the APB outputs, LEDs and flash pins

`timescale 1ns/1ns
`default_nettype none

module periph_checker #(
    parameter int pad_bits = 16
) (
    input  wire        vdp_clk,
    input  wire        vdp_reset,
    input  wire        psel,
    input  wire        penable,
    input  wire        pwrite,
    input  wire [11:0] paddr,
    input  wire [31:0] pwdata,
    input  wire [31:0] prdata,
    input  wire        pready,
    input  wire        pslverr,
    input  wire        led_r,
    input  wire        led_b,
    input  wire        btn_1,
    input  wire        btn_2,
    input  wire        btn_3,
    input  wire        flash_clk,
    input  wire        flash_csn,
    input  wire [3:0]  flash_io_out,
    input  wire [3:0]  flash_io_oe,
    input  wire [3:0]  flash_io_in,
    output int         error_count
);

    logic [1:0]          status_m;
    logic signed [15:0]  op_a_m;
    logic signed [15:0]  op_b_m;
    logic signed [31:0]  product_m;
    logic                pad_latch_m;
    logic                pad_clk_m;
    logic                pad_clk_prev_m;
    logic [pad_bits-1:0] shift_m;
    logic                active_m;
    logic [9:0]          pin_fields_m;
    logic [9:0]          pins_expected;
    logic [3:0]          sample_m;
    logic                access;
    int                  errors = 0;

    assign access      = psel && penable;
    assign error_count = errors;

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("Mismatch %s at %0t ns: expected 0x%0h, got 0x%0h",
                     name, $time, expected, actual);
        end
    endtask

    function automatic logic is_mapped(input logic [11:0] addr);
        return addr inside {periph_pkg::addr_status, periph_pkg::addr_dsp_a,
                            periph_pkg::addr_dsp_b, periph_pkg::addr_pad,
                            periph_pkg::addr_flash};
    endfunction

    function automatic logic [31:0] expected_read(input logic [11:0] addr);
        logic [31:0] value;
        value = '0;
        if (addr == periph_pkg::addr_status) value[1:0] = status_m;
        if (addr == periph_pkg::addr_dsp_a || addr == periph_pkg::addr_dsp_b) value = product_m;
        if (addr == periph_pkg::addr_pad) value[0] = shift_m[0];
        if (addr == periph_pkg::addr_flash) value[3:0] = sample_m;
        return value;
    endfunction

    // Pins packed as {clk, csn, oe, out} with only csn high when idle
    assign pins_expected = active_m ? pin_fields_m : 10'b01_0000_0000;

    always @(posedge vdp_clk) begin
        if (vdp_reset) begin
            // Red LED on and blue LED off
            status_m       <= 2'b01;
            pad_latch_m    <= 1'b0;
            pad_clk_m      <= 1'b0;
            pad_clk_prev_m <= 1'b0;
            active_m       <= 1'b0;
        end else begin
            compare_value("led_b,led_r", 32'(status_m), 32'({led_b, led_r}));
            compare_value("flash_clk,csn,io_oe,io_out", 32'(pins_expected),
                          32'({flash_clk, flash_csn, flash_io_oe, flash_io_out}));
            compare_value("pready", 32'(access), 32'(pready));
            if (access) begin
                compare_value("pslverr", 32'(!is_mapped(paddr)), 32'(pslverr));
                if (!pwrite) begin
                    compare_value("prdata", expected_read(paddr), prdata);
                end
            end else begin
                compare_value("pslverr", 32'd0, 32'(pslverr));
                compare_value("prdata", 32'd0, prdata);
            end
            // Model register writes
            if (access && pwrite) begin
                if (paddr == periph_pkg::addr_status) status_m <= pwdata[1:0];
                if (paddr == periph_pkg::addr_dsp_a) op_a_m <= pwdata[15:0];
                if (paddr == periph_pkg::addr_dsp_b) op_b_m <= pwdata[15:0];
                if (paddr == periph_pkg::addr_pad) begin
                    pad_latch_m <= pwdata[0];
                    pad_clk_m   <= pwdata[1];
                end
                if (paddr == periph_pkg::addr_flash) begin
                    active_m     <= pwdata[periph_pkg::flash_active_bit];
                    pin_fields_m <= {pwdata[periph_pkg::flash_clk_bit],
                                     pwdata[periph_pkg::flash_csn_bit],
                                     pwdata[periph_pkg::flash_oe_lsb +: 4],
                                     pwdata[periph_pkg::flash_out_lsb +: 4]};
                end
            end
            pad_clk_prev_m <= pad_clk_m;
        end
        product_m <= 32'(op_a_m) * 32'(op_b_m);
        sample_m  <= flash_io_in;
        // Software clock edge beats the latch load
        if (pad_clk_m && !pad_clk_prev_m) begin
            shift_m <= shift_m >> 1;
        end else if (pad_latch_m) begin
            shift_m    <= '0;
            shift_m[7] <= btn_1;
            shift_m[6] <= btn_3;
            shift_m[0] <= btn_2;
        end
    end

endmodule

`default_nettype wire

/* test/periph_tb.sv */
// Testbench top for the peripheral block
// LFSR stimulus, APB driver, test sequence, watchdog and final report

`timescale 1ns/1ns
`default_nettype none

module periph_tb;

    localparam logic [31:0] lfsr_seed = 32'd84674;
    localparam int n_transfers  = 16;
    localparam int pad_rounds   = 4;
    localparam int pready_limit = 8;
    // Transfers of all tests, in run order
    localparam int total_transfers = 1 + 2 * n_transfers + 4 * n_transfers
        + 34 * pad_rounds + 2 * n_transfers + 3 * n_transfers;
    localparam int watchdog_ns = total_transfers * 2 * 10 * 2;

    wire         vdp_clk;
    wire         vdp_reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    wire  [31:0] prdata;
    wire         pready;
    wire         pslverr;
    wire         led_r;
    wire         led_b;
    logic        btn_1;
    logic        btn_2;
    logic        btn_3;
    wire         flash_clk;
    wire         flash_csn;
    wire  [3:0]  flash_io_out;
    wire  [3:0]  flash_io_oe;
    logic [3:0]  flash_io_in;
    int          checker_errors;
    int          driver_errors;
    int          errors_seen;
    int          tests_run;
    int          tests_failed;
    logic [31:0] lfsr_state;

    tb_clock #(
        .period_ns    (10),
        .reset_cycles (4)
    ) i_tb_clock (
        .vdp_clk   (vdp_clk),
        .vdp_reset (vdp_reset)
    );

    periph_top #(
        .dsp_width (periph_pkg::dsp_width_default),
        .pad_bits  (periph_pkg::pad_bits_default)
    ) i_periph_top (.*);

    periph_checker #(
        .pad_bits (periph_pkg::pad_bits_default)
    ) i_periph_checker (.*, .error_count(checker_errors));

    // Taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value      = {value[30:0], lfsr_state[31]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return value;
    endfunction

    function automatic logic is_mapped(input logic [11:0] addr);
        return addr inside {periph_pkg::addr_status, periph_pkg::addr_dsp_a,
                            periph_pkg::addr_dsp_b, periph_pkg::addr_pad,
                            periph_pkg::addr_flash};
    endfunction

    // Called on a falling edge, returns on the falling edge after the access
    task automatic apb_transfer(input logic write, input logic [11:0] addr,
                                input logic [31:0] data);
        int waited;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = write ? data : 32'd0;
        @(negedge vdp_clk);
        penable = 1'b1;
        waited  = 0;
        @(posedge vdp_clk);
        while (!pready && waited < pready_limit) begin
            waited++;
            @(posedge vdp_clk);
        end
        if (!pready) begin
            driver_errors++;
            $display("pready never rose for address 0x%03h", addr);
        end
        @(negedge vdp_clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic report_test(input string name);
        int new_errors;
        new_errors  = checker_errors + driver_errors - errors_seen;
        errors_seen = checker_errors + driver_errors;
        tests_run++;
        if (new_errors == 0) begin
            $display("Test %s passed", name);
        end else begin
            tests_failed++;
            $display("Test %s failed with %0d errors", name, new_errors);
        end
    endtask

    initial begin
        #(watchdog_ns);
        $display("Watchdog expired after %0d ns, the tests did not finish", watchdog_ns);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        logic [31:0] value;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        paddr         = '0;
        pwdata        = '0;
        btn_1         = 1'b0;
        btn_2         = 1'b0;
        btn_3         = 1'b0;
        flash_io_in   = 4'h0;
        driver_errors = 0;
        errors_seen   = 0;
        tests_run     = 0;
        tests_failed  = 0;
        lfsr_state    = lfsr_seed;
        wait (vdp_reset == 1'b0);
        @(negedge vdp_clk);

        apb_transfer(1'b0, periph_pkg::addr_status, 32'd0);
        report_test("reset_state");

        for (int i = 0; i < n_transfers; i++) begin
            apb_transfer(1'b1, periph_pkg::addr_status, rand_bits(32));
            apb_transfer(1'b0, periph_pkg::addr_status, 32'd0);
        end
        report_test("status");

        for (int i = 0; i < n_transfers; i++) begin
            apb_transfer(1'b1, periph_pkg::addr_dsp_a, rand_bits(32));
            apb_transfer(1'b1, periph_pkg::addr_dsp_b, rand_bits(32));
            apb_transfer(1'b0, periph_pkg::addr_dsp_a, 32'd0);
            apb_transfer(1'b0, periph_pkg::addr_dsp_b, 32'd0);
        end
        report_test("multiplier");

        // Latch the buttons, then clock out nine bit positions
        for (int i = 0; i < pad_rounds; i++) begin
            value = rand_bits(3);
            btn_1 = value[0];
            btn_2 = value[1];
            btn_3 = value[2];
            apb_transfer(1'b1, periph_pkg::addr_pad, 32'd1);
            apb_transfer(1'b1, periph_pkg::addr_pad, 32'd0);
            for (int j = 0; j < 8; j++) begin
                apb_transfer(1'b1, periph_pkg::addr_pad, 32'd0);
                apb_transfer(1'b0, periph_pkg::addr_pad, 32'd0);
                apb_transfer(1'b1, periph_pkg::addr_pad, 32'd2);
                apb_transfer(1'b0, periph_pkg::addr_pad, 32'd0);
            end
        end
        report_test("gamepad");

        for (int i = 0; i < n_transfers; i++) begin
            value       = rand_bits(4);
            flash_io_in = value[3:0];
            value       = rand_bits(32);
            value[periph_pkg::flash_active_bit] = i[0];
            apb_transfer(1'b1, periph_pkg::addr_flash, value);
            apb_transfer(1'b0, periph_pkg::addr_flash, 32'd0);
        end
        report_test("flash");

        for (int i = 0; i < n_transfers; i++) begin
            value = rand_bits(13);
            while (is_mapped(value[11:0])) begin
                value = rand_bits(13);
            end
            apb_transfer(value[12], value[11:0], rand_bits(32));
            apb_transfer(1'b0, periph_pkg::addr_dsp_a, 32'd0);
            apb_transfer(1'b0, periph_pkg::addr_status, 32'd0);
        end
        report_test("unmapped");

        $display("Tests run: %0d, failed: %0d, errors: %0d",
                 tests_run, tests_failed, checker_errors + driver_errors);
        if (checker_errors + driver_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
source/periph_pkg.sv
source/periph_apb_bus.sv
source/dsp_mult.sv
source/pad_reader.sv
source/flash_bitbang.sv
source/periph_top.sv
test/tb_clock.sv
test/periph_checker.sv
test/periph_tb.sv

/* Makefile */
# Verilator simulation of the peripheral block

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the Verilator build output"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module periph_tb -f flist.f -Mdir obj_dir
	@out="$$(./obj_dir/Vperiph_tb)"; echo "$$out"; echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir
